//--- src/sep_pkg.sv
// tone separator shared definitions
// frame geometry, data widths and controller states
package sep_pkg;

    localparam int frame_len = 1024;
    localparam int half_len  = frame_len / 2;      // peak search stops here
    localparam int adc_w     = 8;
    localparam int bin_w     = 24;
    localparam int idx_w     = $clog2(frame_len);
    localparam int harm_w    = idx_w + 3;          // room for 7 x bin index

    typedef logic [idx_w-1:0] bin_idx_t;
    typedef logic [adc_w-1:0] adc_raw_t;           // offset binary from the ADC
    typedef logic signed [adc_w-1:0] sample_t;     // two's complement to the FFT
    typedef logic signed [bin_w-1:0] bin_t;
    typedef logic [2*bin_w:0] mag_t;               // re^2 + im^2, one spare bit

    typedef enum logic [2:0] {
        st_capture,
        st_feed_fft,
        st_collect,
        st_mask,
        st_feed_ifft,
        st_idle
    } ctrl_state_e;

endpackage

//--- src/adc_frame_capture.sv
// ADC frame capture
// stores one frame of converted samples, then replays it to the FFT under ready
`timescale 1ns/1ps

module adc_frame_capture (
    input  logic              AD0_CLK,
    input  logic              rst,
    input  logic              capture_start,
    input  logic              feed_start,
    input  sep_pkg::adc_raw_t ad0,
    input  logic              fft_in_ready,
    output logic              fft_in_valid,
    output sep_pkg::sample_t  fft_in_data,
    output logic              fft_in_last,
    output logic              feed_done
);

    sep_pkg::sample_t  mem [sep_pkg::frame_len];

    logic              cap_active;
    sep_pkg::bin_idx_t wr_addr;
    logic              feeding;
    sep_pkg::bin_idx_t rd_addr;
    logic              rd_issue;
    logic              rd_pend;         // RAM data lands next cycle
    logic              rd_pend_last;
    sep_pkg::sample_t  ram_q;

    logic              out_valid;
    logic              out_last;
    sep_pkg::sample_t  out_data;
    logic              skid_valid;
    logic              skid_last;
    sep_pkg::sample_t  skid_data;

    logic              pop;
    logic              keep;
    logic              load_out;
    logic [1:0]        occ;

    assign pop      = out_valid & fft_in_ready;
    assign keep     = out_valid & ~fft_in_ready;
    assign load_out = pop | ~out_valid;
    // entries that will still be held or arriving after this cycle
    assign occ      = 2'(keep) + 2'(skid_valid) + 2'(rd_pend);
    assign rd_issue = feeding && (occ < 2'd2);

    // MSB flip turns offset binary into ad0 - 128
    always_ff @(posedge AD0_CLK) begin
        if (cap_active)
            mem[wr_addr] <= sep_pkg::sample_t'({~ad0[sep_pkg::adc_w-1], ad0[sep_pkg::adc_w-2:0]});
        if (rd_issue)
            ram_q <= mem[rd_addr];
    end

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            cap_active   <= 1'b0;
            wr_addr      <= '0;
            feeding      <= 1'b0;
            rd_addr      <= '0;
            rd_pend      <= 1'b0;
            rd_pend_last <= 1'b0;
        end else begin
            if (capture_start) begin
                cap_active <= 1'b1;
                wr_addr    <= '0;
            end else if (cap_active) begin
                wr_addr <= wr_addr + 1'b1;
                if (wr_addr == sep_pkg::bin_idx_t'(sep_pkg::frame_len - 1))
                    cap_active <= 1'b0;
            end
            if (feed_start) begin
                feeding <= 1'b1;
                rd_addr <= '0;
            end else if (rd_issue) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == sep_pkg::bin_idx_t'(sep_pkg::frame_len - 1))
                    feeding <= 1'b0;       // every address issued
            end
            rd_pend      <= rd_issue;
            rd_pend_last <= rd_issue && (rd_addr == sep_pkg::bin_idx_t'(sep_pkg::frame_len - 1));
        end
    end

    // output register and skid flags
    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            out_valid  <= skid_valid | rd_pend;
            skid_valid <= skid_valid & rd_pend;
        end else if (rd_pend) begin
            skid_valid <= 1'b1;        // out is stalled, park the arrival
        end
    end

    always_ff @(posedge AD0_CLK) begin
        if (load_out) begin
            if (skid_valid) begin
                out_data  <= skid_data;
                out_last  <= skid_last;
                skid_data <= ram_q;
                skid_last <= rd_pend_last;
            end else if (rd_pend) begin
                out_data <= ram_q;
                out_last <= rd_pend_last;
            end
        end else if (rd_pend) begin
            skid_data <= ram_q;
            skid_last <= rd_pend_last;
        end
    end

    assign fft_in_valid = out_valid;
    assign fft_in_data  = out_data;
    assign fft_in_last  = out_last;
    assign feed_done    = pop & out_last;

    ast_feed_hold: assert property (@(posedge AD0_CLK) disable iff (rst)
        fft_in_valid && !fft_in_ready |=> fft_in_valid && $stable(fft_in_data));

endmodule

//--- src/peak_search.sv
// two-peak search over the lower half of a returned spectrum
`timescale 1ns/1ps

module peak_search (
    input  logic              AD0_CLK,
    input  logic              rst,
    input  logic              bin_valid,
    input  sep_pkg::bin_idx_t bin_index,
    input  sep_pkg::bin_t     bin_re,
    input  sep_pkg::bin_t     bin_im,
    input  logic              bin_last,
    output sep_pkg::bin_idx_t peak_lo_idx,
    output sep_pkg::bin_idx_t peak_hi_idx
);

    logic signed [2*sep_pkg::bin_w-1:0] re_sq;
    logic signed [2*sep_pkg::bin_w-1:0] im_sq;
    logic              in_range;

    logic              s1_valid;
    sep_pkg::bin_idx_t s1_idx;
    sep_pkg::mag_t     s1_mag;

    logic              b1_vld, b2_vld;
    sep_pkg::bin_idx_t b1_idx, b2_idx;
    sep_pkg::mag_t     b1_mag, b2_mag;
    logic              b1_vld_n, b2_vld_n;
    sep_pkg::bin_idx_t b1_idx_n, b2_idx_n;
    sep_pkg::mag_t     b1_mag_n, b2_mag_n;
    logic              published;

    assign re_sq    = bin_re * bin_re;
    assign im_sq    = bin_im * bin_im;
    assign in_range = (bin_index != '0) &&
                      (bin_index < sep_pkg::bin_idx_t'(sep_pkg::half_len));

    // stage 1 squared magnitude
    always_ff @(posedge AD0_CLK) begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= bin_valid && in_range;
        if (bin_valid) begin
            s1_idx <= bin_index;
            s1_mag <= sep_pkg::mag_t'(re_sq) + sep_pkg::mag_t'(im_sq);
        end
    end

    // strictly larger wins, ties keep the earlier bin
    always_comb begin
        b1_vld_n = b1_vld;
        b1_idx_n = b1_idx;
        b1_mag_n = b1_mag;
        b2_vld_n = b2_vld;
        b2_idx_n = b2_idx;
        b2_mag_n = b2_mag;
        if (s1_valid) begin
            if (!b1_vld || s1_mag > b1_mag) begin
                b2_vld_n = b1_vld;
                b2_idx_n = b1_idx;
                b2_mag_n = b1_mag;
                b1_vld_n = 1'b1;
                b1_idx_n = s1_idx;
                b1_mag_n = s1_mag;
            end else if (!b2_vld || s1_mag > b2_mag) begin
                b2_vld_n = 1'b1;
                b2_idx_n = s1_idx;
                b2_mag_n = s1_mag;
            end
        end
    end

    // publish on bin_last itself; the last bin is frame_len - 1, never in range
    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            b1_vld      <= 1'b0;
            b2_vld      <= 1'b0;
            published   <= 1'b0;
            peak_lo_idx <= '0;
            peak_hi_idx <= '0;
        end else if (bin_valid && bin_last) begin
            b1_vld      <= 1'b0;    // fresh trackers for the next spectrum
            b2_vld      <= 1'b0;
            published   <= 1'b1;
            peak_lo_idx <= (b1_idx_n < b2_idx_n) ? b1_idx_n : b2_idx_n;
            peak_hi_idx <= (b1_idx_n < b2_idx_n) ? b2_idx_n : b1_idx_n;
        end else begin
            b1_vld <= b1_vld_n;
            b2_vld <= b2_vld_n;
        end
    end

    always_ff @(posedge AD0_CLK) begin
        b1_idx <= b1_idx_n;
        b1_mag <= b1_mag_n;
        b2_idx <= b2_idx_n;
        b2_mag <= b2_mag_n;
    end

    ast_peak_order: assert property (@(posedge AD0_CLK) disable iff (rst)
        published |-> peak_lo_idx < peak_hi_idx);

endmodule

//--- src/harmonic_buffer.sv
// spectrum buffer that keeps the odd harmonics of one tone and their mirrors
`timescale 1ns/1ps

module harmonic_buffer (
    input  logic              AD0_CLK,
    input  logic              bin_valid,
    input  sep_pkg::bin_idx_t bin_index,
    input  sep_pkg::bin_t     bin_re,
    input  sep_pkg::bin_t     bin_im,
    input  sep_pkg::bin_idx_t peak_idx,
    input  logic              mask_en,
    input  sep_pkg::bin_idx_t mask_addr,
    input  logic              rd_en,
    input  sep_pkg::bin_idx_t rd_addr,
    output sep_pkg::bin_t     rd_re,
    output sep_pkg::bin_t     rd_im
);

    sep_pkg::bin_t re_mem [sep_pkg::frame_len];
    sep_pkg::bin_t im_mem [sep_pkg::frame_len];

    logic kept;

    // k x peak or its mirror, k = 1, 3, 5, 7, only when inside 1 .. frame_len - 1
    function automatic logic is_kept(input sep_pkg::bin_idx_t addr,
                                     input sep_pkg::bin_idx_t peak);
        logic [sep_pkg::harm_w-1:0] harm;
        logic [sep_pkg::harm_w-1:0] addr_x;
        logic                       hit;
        hit    = 1'b0;
        addr_x = sep_pkg::harm_w'(addr);
        for (int k = 1; k <= 7; k += 2) begin
            harm = sep_pkg::harm_w'(k) * sep_pkg::harm_w'(peak);
            if (harm != '0 && harm < sep_pkg::harm_w'(sep_pkg::frame_len)) begin
                if (addr_x == harm || addr_x == sep_pkg::harm_w'(sep_pkg::frame_len) - harm)
                    hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign kept = is_kept(mask_addr, peak_idx);

    always_ff @(posedge AD0_CLK) begin
        if (bin_valid) begin
            re_mem[bin_index] <= bin_re;
            im_mem[bin_index] <= bin_im;
        end else if (mask_en && !kept) begin
            re_mem[mask_addr] <= '0;     // clear everything off the harmonic set
            im_mem[mask_addr] <= '0;
        end
    end

    // registered read, holds while the IFFT stalls
    always_ff @(posedge AD0_CLK) begin
        if (rd_en) begin
            rd_re <= re_mem[rd_addr];
            rd_im <= im_mem[rd_addr];
        end
    end

endmodule

//--- src/separator_ctrl.sv
// frame sequencer
// capture, FFT feed, bin intake, mask sweep and IFFT feed, then one idle cycle
`timescale 1ns/1ps

module separator_ctrl (
    input  logic              AD0_CLK,
    input  logic              rst,
    input  logic              feed_done,
    input  logic              bin_last,
    input  logic              ifft_ready,
    output logic              capture_start,
    output logic              feed_start,
    output logic              mask_en,
    output sep_pkg::bin_idx_t mask_addr,
    output logic              rd_en,
    output sep_pkg::bin_idx_t rd_addr,
    output logic              ifft_valid,
    output logic              ifft_last
);

    sep_pkg::ctrl_state_e state;
    sep_pkg::bin_idx_t    cnt;          // capture count, then mask address
    logic                 cnt_last;
    logic                 rd_last;
    logic                 rd_done;      // all addresses read out
    logic                 advance;

    assign cnt_last      = cnt == sep_pkg::bin_idx_t'(sep_pkg::frame_len - 1);
    assign rd_last       = rd_addr == sep_pkg::bin_idx_t'(sep_pkg::frame_len - 1);
    assign capture_start = state == sep_pkg::st_idle;
    assign feed_start    = (state == sep_pkg::st_capture) && cnt_last;
    assign mask_en       = state == sep_pkg::st_mask;
    assign mask_addr     = cnt;
    // buffer output register is free or being taken
    assign advance       = !ifft_valid || ifft_ready;
    assign rd_en         = (state == sep_pkg::st_feed_ifft) && advance && !rd_done;

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            state      <= sep_pkg::st_idle;
            cnt        <= '0;
            rd_addr    <= '0;
            rd_done    <= 1'b0;
            ifft_valid <= 1'b0;
            ifft_last  <= 1'b0;
        end else begin
            case (state)
                sep_pkg::st_idle: begin
                    cnt   <= '0;
                    state <= sep_pkg::st_capture;
                end
                sep_pkg::st_capture: begin
                    cnt <= cnt + 1'b1;          // wraps back to 0 for the sweep
                    if (cnt_last)
                        state <= sep_pkg::st_feed_fft;
                end
                sep_pkg::st_feed_fft: begin
                    if (feed_done)
                        state <= sep_pkg::st_collect;
                end
                sep_pkg::st_collect: begin
                    if (bin_last)
                        state <= sep_pkg::st_mask;
                end
                sep_pkg::st_mask: begin
                    cnt <= cnt + 1'b1;
                    if (cnt_last) begin
                        state   <= sep_pkg::st_feed_ifft;
                        rd_addr <= '0;
                        rd_done <= 1'b0;
                    end
                end
                sep_pkg::st_feed_ifft: begin
                    if (rd_en) begin
                        rd_addr    <= rd_addr + 1'b1;
                        ifft_valid <= 1'b1;     // data shows up with the read
                        ifft_last  <= rd_last;
                        rd_done    <= rd_last;
                    end else if (advance) begin
                        ifft_valid <= 1'b0;
                        ifft_last  <= 1'b0;
                    end
                    if (ifft_valid && ifft_ready && ifft_last)
                        state <= sep_pkg::st_idle;
                end
                default: state <= sep_pkg::st_idle;
            endcase
        end
    end

    ast_ifft_window: assert property (@(posedge AD0_CLK) disable iff (rst)
        ifft_valid |-> state == sep_pkg::st_feed_ifft);

endmodule

//--- src/tone_separator.sv
// two-tone separator top
// ADC frame to FFT, peak search, two harmonic masks, both channels to the IFFT
`timescale 1ns/1ps

module tone_separator (
    input  logic              AD0_CLK,
    input  logic              rst,
    input  sep_pkg::adc_raw_t ad0,
    input  logic              fft_in_ready,
    output logic              fft_in_valid,
    output sep_pkg::sample_t  fft_in_data,
    output logic              fft_in_last,
    input  logic              bin_valid,
    input  sep_pkg::bin_idx_t bin_index,
    input  sep_pkg::bin_t     bin_re,
    input  sep_pkg::bin_t     bin_im,
    input  logic              bin_last,
    input  logic              ifft_ready,
    output logic              ifft_valid,
    output logic              ifft_last,
    output sep_pkg::bin_t     ch0_re,
    output sep_pkg::bin_t     ch0_im,
    output sep_pkg::bin_t     ch1_re,
    output sep_pkg::bin_t     ch1_im,
    output sep_pkg::bin_idx_t peak_lo_idx,
    output sep_pkg::bin_idx_t peak_hi_idx
);

    logic              capture_start;
    logic              feed_start;
    logic              feed_done;
    logic              mask_en;
    sep_pkg::bin_idx_t mask_addr;
    logic              rd_en;
    sep_pkg::bin_idx_t rd_addr;

    separator_ctrl u_ctrl (
        .AD0_CLK       (AD0_CLK),
        .rst           (rst),
        .feed_done     (feed_done),
        .bin_last      (bin_last),
        .ifft_ready    (ifft_ready),
        .capture_start (capture_start),
        .feed_start    (feed_start),
        .mask_en       (mask_en),
        .mask_addr     (mask_addr),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .ifft_valid    (ifft_valid),
        .ifft_last     (ifft_last)
    );

    adc_frame_capture u_capture (
        .AD0_CLK       (AD0_CLK),
        .rst           (rst),
        .capture_start (capture_start),
        .feed_start    (feed_start),
        .ad0           (ad0),
        .fft_in_ready  (fft_in_ready),
        .fft_in_valid  (fft_in_valid),
        .fft_in_data   (fft_in_data),
        .fft_in_last   (fft_in_last),
        .feed_done     (feed_done)
    );

    peak_search u_peaks (
        .AD0_CLK     (AD0_CLK),
        .rst         (rst),
        .bin_valid   (bin_valid),
        .bin_index   (bin_index),
        .bin_re      (bin_re),
        .bin_im      (bin_im),
        .bin_last    (bin_last),
        .peak_lo_idx (peak_lo_idx),
        .peak_hi_idx (peak_hi_idx)
    );

    // lower tone
    harmonic_buffer u_ch0 (
        .AD0_CLK   (AD0_CLK),
        .bin_valid (bin_valid),
        .bin_index (bin_index),
        .bin_re    (bin_re),
        .bin_im    (bin_im),
        .peak_idx  (peak_lo_idx),
        .mask_en   (mask_en),
        .mask_addr (mask_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_re     (ch0_re),
        .rd_im     (ch0_im)
    );

    // higher tone
    harmonic_buffer u_ch1 (
        .AD0_CLK   (AD0_CLK),
        .bin_valid (bin_valid),
        .bin_index (bin_index),
        .bin_re    (bin_re),
        .bin_im    (bin_im),
        .peak_idx  (peak_hi_idx),
        .mask_en   (mask_en),
        .mask_addr (mask_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_re     (ch1_re),
        .rd_im     (ch1_im)
    );

endmodule

//--- dv/tb_tasks.svh
// tone separator testbench helpers
// LCG, reference model, compare tasks, ADC/FFT/IFFT models and the directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int unsigned lcg_seed       = 93062;
localparam int          timeout_cycles = 5 * 5 * sep_pkg::frame_len; // 5 frames, 5 phases

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;                 // low bits of an LCG repeat too soon
endfunction

// ready three cycles out of four under back-pressure
function automatic logic draw_ready(input bit backpressure);
    if (!backpressure)
        return 1'b1;
    return (lcg_next() % 4) != 0;
endfunction

task automatic check_sample(input sep_pkg::sample_t got, input sep_pkg::sample_t exp,
                            input string what);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bin(input sep_pkg::bin_t got, input sep_pkg::bin_t exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_idx(input sep_pkg::bin_idx_t got, input sep_pkg::bin_idx_t exp,
                         input string what);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
        tests_passed++;
        $display("test %s: pass", name);
    end else begin
        tests_failed++;
        $display("test %s: FAIL with %0d errors", name, error_count - errs_before);
    end
endtask

// odd harmonics 1..7 of the peak and their mirrors, inside 1 .. frame_len - 1
function automatic bit in_kept_set(input int addr, input int peak);
    int h;
    for (int k = 1; k <= 7; k += 2) begin
        h = k * peak;
        if (h >= 1 && h <= sep_pkg::frame_len - 1) begin
            if (addr == h || addr == sep_pkg::frame_len - h)
                return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic load_ramp(input int start, input int step);
    for (int i = 0; i < sep_pkg::frame_len; i++)
        adc_frame[i] = sep_pkg::adc_raw_t'(start + step * i);
endtask

task automatic fill_background();
    for (int i = 0; i < sep_pkg::frame_len; i++) begin
        spec_re[i] = sep_pkg::bin_t'(int'(lcg_next() % 31) - 15);   // noise floor +-15
        spec_im[i] = sep_pkg::bin_t'(int'(lcg_next() % 31) - 15);
    end
endtask

// tone plus its conjugate mirror, as a real signal would give
task automatic place_tone(input int idx, input int re, input int im);
    spec_re[idx] = sep_pkg::bin_t'(re);
    spec_im[idx] = sep_pkg::bin_t'(im);
    spec_re[sep_pkg::frame_len - idx] = sep_pkg::bin_t'(re);
    spec_im[sep_pkg::frame_len - idx] = sep_pkg::bin_t'(-im);
endtask

// first negedge lets the idle cycle of the controller pass
task automatic capture_frame();
    @(negedge AD0_CLK);
    for (int i = 0; i < sep_pkg::frame_len; i++) begin
        ad0 = adc_frame[i];
        @(negedge AD0_CLK);
    end
endtask

// FFT side, takes the frame and checks it sample by sample
task automatic play_fft(input bit backpressure);
    int               count;
    bit               done;
    bit               hold;
    sep_pkg::sample_t held;
    sep_pkg::sample_t exp;
    count = 0;
    done  = 1'b0;
    hold  = 1'b0;
    held  = '0;
    while (!done) begin
        if (hold && (!fft_in_valid || fft_in_data !== held)) begin
            error_count++;
            $display("[ERROR] %0t: FFT feed sample changed while ready was low", $time);
        end
        fft_in_ready = draw_ready(backpressure);
        if (fft_in_valid && fft_in_ready) begin
            exp = sep_pkg::sample_t'(int'(adc_frame[count]) - 128);
            check_sample(fft_in_data, exp, $sformatf("FFT sample %0d", count));
            check_flag(fft_in_last, count == sep_pkg::frame_len - 1,
                       $sformatf("fft_in_last at sample %0d", count));
            done = fft_in_last || count == sep_pkg::frame_len - 1;
            count++;
        end
        hold = fft_in_valid && !fft_in_ready;
        held = fft_in_data;
        @(negedge AD0_CLK);
    end
    if (count != sep_pkg::frame_len) begin
        error_count++;
        $display("FFT feed ended after %0d samples instead of a full frame", count);
    end
endtask

task automatic return_spectrum();
    for (int i = 0; i < sep_pkg::frame_len; i++) begin
        bin_valid = 1'b1;
        bin_index = sep_pkg::bin_idx_t'(i);
        bin_re    = spec_re[i];
        bin_im    = spec_im[i];
        bin_last  = (i == sep_pkg::frame_len - 1);
        @(negedge AD0_CLK);
    end
    bin_valid = 1'b0;   // must be low before the mask sweep
    bin_last  = 1'b0;
endtask

// IFFT side, both channels against the masked reference spectrum
task automatic drain_ifft(input bit backpressure, input int lo, input int hi);
    int            count;
    bit            done;
    sep_pkg::bin_t zero;
    count = 0;
    done  = 1'b0;
    zero  = '0;
    while (!done) begin
        ifft_ready = draw_ready(backpressure);
        if (ifft_valid && ifft_ready) begin
            check_bin(ch0_re, in_kept_set(count, lo) ? spec_re[count] : zero,
                      $sformatf("ch0_re bin %0d", count));
            check_bin(ch0_im, in_kept_set(count, lo) ? spec_im[count] : zero,
                      $sformatf("ch0_im bin %0d", count));
            check_bin(ch1_re, in_kept_set(count, hi) ? spec_re[count] : zero,
                      $sformatf("ch1_re bin %0d", count));
            check_bin(ch1_im, in_kept_set(count, hi) ? spec_im[count] : zero,
                      $sformatf("ch1_im bin %0d", count));
            check_flag(ifft_last, count == sep_pkg::frame_len - 1,
                       $sformatf("ifft_last at bin %0d", count));
            done = ifft_last || count == sep_pkg::frame_len - 1;
            count++;
        end
        @(negedge AD0_CLK);
    end
endtask

task automatic offset_conversion_test();
    int errs;
    errs = error_count;
    load_ramp(0, 1);
    capture_frame();
    play_fft(1'b0);
    report_test("offset conversion", errs);
endtask

task automatic peak_search_test();
    int errs;
    errs = error_count;
    fill_background();
    place_tone(37, 6000, -2500);
    place_tone(111, 4500, 3000);      // also 3 x 37
    place_tone(185, 900, -400);       // 5 x 37, weak
    return_spectrum();
    check_idx(peak_lo_idx, sep_pkg::bin_idx_t'(37), "peak_lo_idx");
    check_idx(peak_hi_idx, sep_pkg::bin_idx_t'(111), "peak_hi_idx");
    report_test("peak search", errs);
endtask

task automatic harmonic_masking_test();
    int errs;
    errs = error_count;
    drain_ifft(1'b0, 37, 111);
    report_test("harmonic masking", errs);
endtask

task automatic fft_backpressure_test();
    int errs;
    errs = error_count;
    load_ramp(17, 3);
    capture_frame();
    play_fft(1'b1);
    report_test("FFT back-pressure", errs);
endtask

task automatic peak_order_test();
    int errs;
    errs = error_count;
    fill_background();
    place_tone(53, 4200, 1000);
    place_tone(159, 700, 300);
    place_tone(200, 9000, -3000);     // strongest at the higher bin
    return_spectrum();
    check_idx(peak_lo_idx, sep_pkg::bin_idx_t'(53), "peak_lo_idx");
    check_idx(peak_hi_idx, sep_pkg::bin_idx_t'(200), "peak_hi_idx");
    report_test("peak order", errs);
endtask

task automatic ifft_backpressure_test();
    int errs;
    errs = error_count;
    drain_ifft(1'b1, 53, 200);
    report_test("IFFT back-pressure", errs);
endtask

task automatic frame_repeat_test();
    int errs;
    errs = error_count;
    load_ramp(200, 7);
    capture_frame();
    play_fft(1'b1);
    fill_background();
    place_tone(90, 5000, 5000);
    place_tone(270, 600, 0);
    place_tone(300, -7000, 2000);
    return_spectrum();
    check_idx(peak_lo_idx, sep_pkg::bin_idx_t'(90), "peak_lo_idx");
    check_idx(peak_hi_idx, sep_pkg::bin_idx_t'(300), "peak_hi_idx");
    drain_ifft(1'b1, 90, 300);
    report_test("frame repeat", errs);
endtask

`endif

//--- dv/tone_separator_tb.sv
// testbench for the two-tone separator
// models the ADC, FFT and IFFT around the DUT and runs the directed tests
`timescale 1ns/1ps

module tone_separator_tb;

    logic              AD0_CLK;
    logic              rst;
    sep_pkg::adc_raw_t ad0;
    logic              fft_in_ready;
    logic              fft_in_valid;
    sep_pkg::sample_t  fft_in_data;
    logic              fft_in_last;
    logic              bin_valid;
    sep_pkg::bin_idx_t bin_index;
    sep_pkg::bin_t     bin_re;
    sep_pkg::bin_t     bin_im;
    logic              bin_last;
    logic              ifft_ready;
    logic              ifft_valid;
    logic              ifft_last;
    sep_pkg::bin_t     ch0_re;
    sep_pkg::bin_t     ch0_im;
    sep_pkg::bin_t     ch1_re;
    sep_pkg::bin_t     ch1_im;
    sep_pkg::bin_idx_t peak_lo_idx;
    sep_pkg::bin_idx_t peak_hi_idx;

    // stimulus of the current frame
    sep_pkg::adc_raw_t adc_frame [sep_pkg::frame_len];
    sep_pkg::bin_t     spec_re [sep_pkg::frame_len];
    sep_pkg::bin_t     spec_im [sep_pkg::frame_len];

    int unsigned lcg_state;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    `include "tb_tasks.svh"

    tone_separator tone_separator_i (
        .AD0_CLK      (AD0_CLK),
        .rst          (rst),
        .ad0          (ad0),
        .fft_in_ready (fft_in_ready),
        .fft_in_valid (fft_in_valid),
        .fft_in_data  (fft_in_data),
        .fft_in_last  (fft_in_last),
        .bin_valid    (bin_valid),
        .bin_index    (bin_index),
        .bin_re       (bin_re),
        .bin_im       (bin_im),
        .bin_last     (bin_last),
        .ifft_ready   (ifft_ready),
        .ifft_valid   (ifft_valid),
        .ifft_last    (ifft_last),
        .ch0_re       (ch0_re),
        .ch0_im       (ch0_im),
        .ch1_re       (ch1_re),
        .ch1_im       (ch1_im),
        .peak_lo_idx  (peak_lo_idx),
        .peak_hi_idx  (peak_hi_idx)
    );

    always #5 AD0_CLK = ~AD0_CLK;     // 10 ns period

    // run limit
    always @(posedge AD0_CLK) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the test sequence did not finish within %0d cycles",
                     timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        AD0_CLK      = 1'b0;
        rst          = 1'b1;
        ad0          = '0;
        fft_in_ready = 1'b0;
        bin_valid    = 1'b0;
        bin_index    = '0;
        bin_re       = '0;
        bin_im       = '0;
        bin_last     = 1'b0;
        ifft_ready   = 1'b0;
        lcg_state    = lcg_seed;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;

        repeat (16) @(negedge AD0_CLK);
        rst = 1'b0;

        // frame 1, no back-pressure
        offset_conversion_test();
        peak_search_test();
        harmonic_masking_test();
        // frame 2, back-pressure on both feeds
        fft_backpressure_test();
        peak_order_test();
        ifft_backpressure_test();
        // frame 3, new ramp and new tones
        frame_repeat_test();

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+dv
src/sep_pkg.sv
src/adc_frame_capture.sv
src/peak_search.sv
src/harmonic_buffer.sv
src/separator_ctrl.sv
src/tone_separator.sv
dv/tone_separator_tb.sv

//--- Makefile
# Verilator flow for the tone separator
# variables can be overridden on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP       ?= tone_separator_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the testbench printed the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
